//--- compile.f
+incdir+logic
logic/exe_pkg.sv
logic/exe_alu.sv
logic/exe_divider.sv
logic/exe_hilo_unit.sv
logic/exe_stage.sv
verif/exe_stage_props.sv
verif/exe_stage_tb.sv

//--- logic/exe_alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "exe_defs.svh"

module exe_alu (
    input  wire exe_pkg::exe_req_t   req_i,
    input  wire [`EXE_WORD_W-1:0]    move_res_i,
    output exe_pkg::exe_wb_t         wb_o,
    output logic                     ov_o
);

    import exe_pkg::*;

    localparam int W = `EXE_WORD_W;

    logic [W-1:0]            logic_res;
    logic [W-1:0]            shift_res;
    logic [W-1:0]            arith_res;
    logic [`EXE_SHAMT_W-1:0] shamt;
    logic                    is_sub;
    logic [W-1:0]            addend;
    logic [W-1:0]            sum;

    always_comb begin
        case (req_i.aluop)
            OP_AND:  logic_res = req_i.src1 & req_i.src2;
            OP_OR:   logic_res = req_i.src1 | req_i.src2;
            OP_XOR:  logic_res = req_i.src1 ^ req_i.src2;
            OP_NOR:  logic_res = ~(req_i.src1 | req_i.src2);
            // upper immediate is already shifted into place by decode
            OP_LUI:  logic_res = req_i.src2;
            default: logic_res = '0;
        endcase
    end

    // fixed and variable shifts differ only in decode
    assign shamt = req_i.src1[`EXE_SHAMT_W-1:0];

    always_comb begin
        case (req_i.aluop)
            OP_SLL, OP_SLLV: shift_res = req_i.src2 << shamt;
            OP_SRL, OP_SRLV: shift_res = req_i.src2 >> shamt;
            OP_SRA, OP_SRAV: shift_res = $signed(req_i.src2) >>> shamt;
            default:         shift_res = '0;
        endcase
    end

    // one adder for add and subtract with subtract as a + ~b + 1
    assign is_sub = (req_i.aluop == OP_SUB) || (req_i.aluop == OP_SUBU);
    assign addend = is_sub ? ~req_i.src2 : req_i.src2;
    assign sum    = req_i.src1 + addend + {{(W-1){1'b0}}, is_sub};

    always_comb begin
        case (req_i.aluop)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: arith_res = sum;
            OP_SLT:  arith_res = {{(W-1){1'b0}}, $signed(req_i.src1) < $signed(req_i.src2)};
            OP_SLTU: arith_res = {{(W-1){1'b0}}, req_i.src1 < req_i.src2};
            default: arith_res = '0;
        endcase
    end

    // overflow when same-sign adder inputs give a result of the other sign
    assign ov_o = ((req_i.aluop == OP_ADD) || (req_i.aluop == OP_SUB))
               && (req_i.src1[W-1] == addend[W-1])
               && (sum[W-1] != req_i.src1[W-1]);

    assign wb_o.wa   = req_i.wa;
    assign wb_o.wreg = req_i.wreg;

    always_comb begin
        case (req_i.alutype)
            TYPE_LOGIC: wb_o.wd = logic_res;
            TYPE_SHIFT: wb_o.wd = shift_res;
            TYPE_ARITH: wb_o.wd = arith_res;
            TYPE_MOVE:  wb_o.wd = move_res_i;
            default:    wb_o.wd = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/exe_defs.svh
`ifndef EXE_DEFS_SVH
`define EXE_DEFS_SVH

// datapath widths
`define EXE_WORD_W      32
`define EXE_DWORD_W     (2 * `EXE_WORD_W)
`define EXE_REG_ADDR_W  5

// shift amount comes from the low bits of src1
`define EXE_SHAMT_W     5

// radix-4 divider
// two quotient bits retired per step, so 16 steps cover a 32-bit word
`define EXE_DIV_STEPS   16

// step counter must reach EXE_DIV_STEPS itself
`define EXE_DIV_CNT_W   5

`endif

//--- logic/exe_divider.sv
`timescale 1ns/100ps
`default_nettype none

`include "exe_defs.svh"

module exe_divider (
    input  wire                     cpu_clk_50M,
    input  wire                     arst_n_i,
    input  wire                     div_req_i,
    input  wire                     div_signed_i,
    input  wire [`EXE_WORD_W-1:0]   dividend_i,
    input  wire [`EXE_WORD_W-1:0]   divisor_i,
    output logic                    div_done_o,
    output exe_pkg::div_res_t       div_res_o
);

    import exe_pkg::*;

    localparam int W = `EXE_WORD_W;
    localparam logic [`EXE_DIV_CNT_W-1:0] LAST_STEP = `EXE_DIV_CNT_W'(`EXE_DIV_STEPS);

    typedef enum logic [1:0] {
        DIV_FREE,
        DIV_BY_ZERO,
        DIV_ON,
        DIV_END
    } div_state_e;

    div_state_e                state_q;
    logic [`EXE_DIV_CNT_W-1:0] cnt_q;

    logic [W-1:0] rem_q;
    // dividend bits shift out of the top as quotient bits shift in below
    logic [W-1:0] quot_q;
    logic [W-1:0] dsor_q;
    logic         neg_quot_q;
    logic         neg_rem_q;
    div_res_t     res_q;

    logic [W-1:0] dend_abs;
    logic [W-1:0] dsor_abs;
    logic [W+1:0] shifted;
    logic [W+1:0] dsor_x2;
    logic [W+1:0] dsor_x3;
    logic [W+2:0] diff1;
    logic [W+2:0] diff2;
    logic [W+2:0] diff3;
    logic [W-1:0] rem_next;
    logic [1:0]   qbits;

    assign dend_abs = (div_signed_i && dividend_i[W-1]) ? ~dividend_i + 1'b1 : dividend_i;
    assign dsor_abs = (div_signed_i && divisor_i[W-1]) ? ~divisor_i + 1'b1 : divisor_i;

    // bring down the next two dividend bits
    assign shifted = {rem_q, quot_q[W-1 -: 2]};
    assign dsor_x2 = {1'b0, dsor_q, 1'b0};
    assign dsor_x3 = dsor_x2 + {2'b00, dsor_q};

    assign diff1 = {1'b0, shifted} - {3'b000, dsor_q};
    assign diff2 = {1'b0, shifted} - {1'b0, dsor_x2};
    assign diff3 = {1'b0, shifted} - {1'b0, dsor_x3};

    // largest multiple that still fits gives the quotient digit
    always_comb begin
        if (!diff3[W+2]) begin
            qbits    = 2'd3;
            rem_next = diff3[W-1:0];
        end else if (!diff2[W+2]) begin
            qbits    = 2'd2;
            rem_next = diff2[W-1:0];
        end else if (!diff1[W+2]) begin
            qbits    = 2'd1;
            rem_next = diff1[W-1:0];
        end else begin
            qbits    = 2'd0;
            rem_next = shifted[W-1:0];
        end
    end

    always_ff @(posedge cpu_clk_50M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= DIV_FREE;
            cnt_q      <= '0;
            div_done_o <= 1'b0;
        end else begin
            case (state_q)
                DIV_FREE: begin
                    if (div_req_i) begin
                        cnt_q   <= '0;
                        state_q <= (divisor_i == '0) ? DIV_BY_ZERO : DIV_ON;
                    end
                end
                DIV_BY_ZERO: begin
                    state_q    <= DIV_END;
                    div_done_o <= 1'b1;
                end
                DIV_ON: begin
                    if (cnt_q == LAST_STEP) begin
                        state_q    <= DIV_END;
                        div_done_o <= 1'b1;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                DIV_END: begin
                    if (!div_req_i) begin
                        state_q    <= DIV_FREE;
                        div_done_o <= 1'b0;
                    end
                end
                default: state_q <= DIV_FREE;
            endcase
        end
    end

    always_ff @(posedge cpu_clk_50M) begin
        case (state_q)
            DIV_FREE: begin
                if (div_req_i) begin
                    rem_q      <= '0;
                    quot_q     <= dend_abs;
                    dsor_q     <= dsor_abs;
                    neg_quot_q <= div_signed_i & (dividend_i[W-1] ^ divisor_i[W-1]);
                    neg_rem_q  <= div_signed_i & dividend_i[W-1];
                end
            end
            DIV_BY_ZERO: res_q <= '0;
            DIV_ON: begin
                if (cnt_q != LAST_STEP) begin
                    rem_q  <= rem_next;
                    quot_q <= {quot_q[W-3:0], qbits};
                end else begin
                    // sign fix with the remainder following the dividend
                    res_q.quot <= neg_quot_q ? ~quot_q + 1'b1 : quot_q;
                    res_q.rem  <= neg_rem_q ? ~rem_q + 1'b1 : rem_q;
                end
            end
            default: ;
        endcase
    end

    assign div_res_o = res_q;

endmodule

`default_nettype wire

//--- logic/exe_hilo_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "exe_defs.svh"

module exe_hilo_unit (
    input  wire                       cpu_clk_50M,
    input  wire                       arst_n_i,
    input  wire exe_pkg::exe_req_t    req_i,
    input  wire exe_pkg::hilo_t       hilo_i,
    input  wire exe_pkg::hilo_wr_t    mem_fwd_i,
    input  wire exe_pkg::hilo_wr_t    wb_fwd_i,
    output logic [`EXE_WORD_W-1:0]    move_res_o,
    output exe_pkg::hilo_wr_t         hilo_wr_o,
    output logic                      stall_o
);

    import exe_pkg::*;

    localparam int W = `EXE_WORD_W;

    logic [W-1:0]            hi_fwd;
    logic [W-1:0]            lo_fwd;
    logic [W-1:0]            src1_mag;
    logic [W-1:0]            src2_mag;
    logic                    mult_neg;
    logic [`EXE_DWORD_W-1:0] prod_mag;
    logic [`EXE_DWORD_W-1:0] prod_signed;
    logic [`EXE_DWORD_W-1:0] prod_unsigned;
    logic                    is_div;
    logic                    div_req;
    logic                    div_signed;
    logic                    div_done;
    div_res_t                div_res;

    // nearest pending write wins for each half
    assign hi_fwd = mem_fwd_i.whi ? mem_fwd_i.hilo.hi :
                    wb_fwd_i.whi  ? wb_fwd_i.hilo.hi  : hilo_i.hi;
    assign lo_fwd = mem_fwd_i.wlo ? mem_fwd_i.hilo.lo :
                    wb_fwd_i.wlo  ? wb_fwd_i.hilo.lo  : hilo_i.lo;

    assign move_res_o = (req_i.aluop == OP_MFHI) ? hi_fwd :
                        (req_i.aluop == OP_MFLO) ? lo_fwd : '0;

    // signed multiply on magnitudes with a negation at the end
    assign src1_mag    = req_i.src1[W-1] ? ~req_i.src1 + 1'b1 : req_i.src1;
    assign src2_mag    = req_i.src2[W-1] ? ~req_i.src2 + 1'b1 : req_i.src2;
    assign mult_neg    = req_i.src1[W-1] ^ req_i.src2[W-1];
    assign prod_mag    = {{W{1'b0}}, src1_mag} * {{W{1'b0}}, src2_mag};
    assign prod_signed = mult_neg ? ~prod_mag + 1'b1 : prod_mag;
    assign prod_unsigned = {{W{1'b0}}, req_i.src1} * {{W{1'b0}}, req_i.src2};

    assign is_div     = (req_i.aluop == OP_DIV) || (req_i.aluop == OP_DIVU);
    assign div_signed = (req_i.aluop == OP_DIV);
    // request drops once done so the divider idles the following cycle
    assign div_req    = is_div & ~div_done;
    assign stall_o    = div_req;

    exe_divider divider_inst (
        .cpu_clk_50M  (cpu_clk_50M),
        .arst_n_i     (arst_n_i),
        .div_req_i    (div_req),
        .div_signed_i (div_signed),
        .dividend_i   (req_i.src1),
        .divisor_i    (req_i.src2),
        .div_done_o   (div_done),
        .div_res_o    (div_res)
    );

    always_comb begin
        hilo_wr_o = '0;
        case (req_i.aluop)
            OP_MULT: begin
                hilo_wr_o.whi  = 1'b1;
                hilo_wr_o.wlo  = 1'b1;
                hilo_wr_o.hilo = prod_signed;
            end
            OP_MULTU: begin
                hilo_wr_o.whi  = 1'b1;
                hilo_wr_o.wlo  = 1'b1;
                hilo_wr_o.hilo = prod_unsigned;
            end
            OP_MTHI: begin
                hilo_wr_o.whi  = 1'b1;
                hilo_wr_o.hilo = {req_i.src1, lo_fwd};
            end
            OP_MTLO: begin
                hilo_wr_o.wlo  = 1'b1;
                hilo_wr_o.hilo = {hi_fwd, req_i.src1};
            end
            OP_DIV, OP_DIVU: begin
                hilo_wr_o.whi = div_done;
                hilo_wr_o.wlo = div_done;
                if (div_done) begin
                    hilo_wr_o.hilo = {div_res.rem, div_res.quot};
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/exe_pkg.sv
`default_nettype none

`include "exe_defs.svh"

package exe_pkg;

    typedef enum logic [7:0] {
        OP_NOP = 8'h00,
        OP_AND, OP_OR, OP_XOR, OP_NOR, OP_LUI,
        OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
        OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
        OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO
    } aluop_e;

    // picks the write-data source
    typedef enum logic [2:0] {
        TYPE_NOP   = 3'd0,
        TYPE_LOGIC = 3'd1,
        TYPE_SHIFT = 3'd2,
        TYPE_ARITH = 3'd3,
        TYPE_MOVE  = 3'd4
    } alutype_e;

    typedef struct packed {
        alutype_e                   alutype;
        aluop_e                     aluop;
        logic [`EXE_WORD_W-1:0]     src1;
        logic [`EXE_WORD_W-1:0]     src2;
        logic [`EXE_REG_ADDR_W-1:0] wa;
        logic                       wreg;
    } exe_req_t;

    typedef struct packed {
        logic [`EXE_REG_ADDR_W-1:0] wa;
        logic                       wreg;
        logic [`EXE_WORD_W-1:0]     wd;
    } exe_wb_t;

    typedef struct packed {
        logic [`EXE_WORD_W-1:0] hi;
        logic [`EXE_WORD_W-1:0] lo;
    } hilo_t;

    // pending or outgoing HI/LO write with one flag per half
    typedef struct packed {
        logic  whi;
        logic  wlo;
        hilo_t hilo;
    } hilo_wr_t;

    typedef struct packed {
        logic [`EXE_WORD_W-1:0] rem;
        logic [`EXE_WORD_W-1:0] quot;
    } div_res_t;

endpackage

`default_nettype wire

//--- logic/exe_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "exe_defs.svh"

module exe_stage (
    input  wire                       cpu_clk_50M,
    input  wire                       arst_n_i,

    // instruction from decode
    input  wire exe_pkg::exe_req_t    req_i,

    // committed HI/LO and pending writes further down the pipe
    input  wire exe_pkg::hilo_t       hilo_i,
    input  wire exe_pkg::hilo_wr_t    mem_fwd_i,
    input  wire exe_pkg::hilo_wr_t    wb_fwd_i,

    output wire exe_pkg::exe_wb_t     wb_o,
    output wire exe_pkg::hilo_wr_t    hilo_wr_o,
    output wire                       ov_o,

    // held high while a divide is in flight
    output wire                       stall_o
);

    // MFHI/MFLO value handed to the write-data mux
    wire [`EXE_WORD_W-1:0] move_res;

    exe_alu alu_inst (
        .req_i      (req_i),
        .move_res_i (move_res),
        .wb_o       (wb_o),
        .ov_o       (ov_o)
    );

    exe_hilo_unit hilo_unit_inst (
        .cpu_clk_50M (cpu_clk_50M),
        .arst_n_i    (arst_n_i),
        .req_i       (req_i),
        .hilo_i      (hilo_i),
        .mem_fwd_i   (mem_fwd_i),
        .wb_fwd_i    (wb_fwd_i),
        .move_res_o  (move_res),
        .hilo_wr_o   (hilo_wr_o),
        .stall_o     (stall_o)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -Wno-fatal -f compile.f \
        --top-module exe_stage_tb -o exe_stage_sim &&
    ./obj_dir/exe_stage_sim | tee /dev/stderr | grep -q "All tests passed!" &&
    echo "simulation passed" ||
    { echo "simulation failed" >&2; exit 1; }

//--- verif/exe_stage_props.sv
`timescale 1ns/100ps
`default_nettype none

module exe_stage_props (
    input wire cpu_clk_50M,
    input wire arst_n_i,
    input wire is_div_i,
    input wire div_req_i,
    input wire div_done_i,
    input wire stall_i
);

    localparam int STALL_MAX = 40;

    // length of the current stall run
    logic [7:0] stall_cnt_q;

    always_ff @(posedge cpu_clk_50M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stall_cnt_q <= '0;
        end else if (stall_i) begin
            stall_cnt_q <= stall_cnt_q + 8'd1;
        end else begin
            stall_cnt_q <= '0;
        end
    end

    // a fresh divide must find the divider idle and stall the pipe
    div_raises_stall: assert property (
        @(posedge cpu_clk_50M) disable iff (!arst_n_i)
        $rose(is_div_i) |-> stall_i
    ) else $error("divide opcode arrived without raising stall_o");

    done_clears: assert property (
        @(posedge cpu_clk_50M) disable iff (!arst_n_i)
        $fell(div_req_i) |=> !div_done_i
    ) else $error("div_done_o still high one cycle after the request dropped");

    stall_bounded: assert property (
        @(posedge cpu_clk_50M) disable iff (!arst_n_i)
        stall_i |-> (stall_cnt_q < STALL_MAX)
    ) else $error("stall_o held high for too many cycles");

endmodule

`default_nettype wire

//--- verif/exe_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "exe_defs.svh"

module exe_stage_tb;

    import exe_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int DRIVE_DLY   = 1;
    // sample point just ahead of the next edge
    localparam int SAMPLE_OFS  = CLK_PERIOD - 2;
    localparam int SAMPLE_DLY  = SAMPLE_OFS - DRIVE_DLY;
    localparam int DIV_TIMEOUT = 100;
    localparam int NUM_FIELDS  = 19;
    localparam int MAX_VEC     = 64;
    localparam logic [31:0] END_MARK = 32'hff;

    logic     cpu_clk_50M;
    logic     arst_n_i;
    exe_req_t req_i;
    hilo_t    hilo_i;
    hilo_wr_t mem_fwd_i;
    hilo_wr_t wb_fwd_i;
    exe_wb_t  wb_o;
    hilo_wr_t hilo_wr_o;
    logic     ov_o;
    logic     stall_o;

    // one 32-bit word per field and NUM_FIELDS words per vector
    logic [31:0] vec_mem [0:NUM_FIELDS*MAX_VEC-1];

    exe_wb_t  exp_wb;
    hilo_wr_t exp_hilo;
    logic     exp_ov;
    int       cur_vec;

    exe_stage exe_stage_inst (
        .cpu_clk_50M (cpu_clk_50M),
        .arst_n_i    (arst_n_i),
        .req_i       (req_i),
        .hilo_i      (hilo_i),
        .mem_fwd_i   (mem_fwd_i),
        .wb_fwd_i    (wb_fwd_i),
        .wb_o        (wb_o),
        .hilo_wr_o   (hilo_wr_o),
        .ov_o        (ov_o),
        .stall_o     (stall_o)
    );

    bind exe_hilo_unit exe_stage_props props_inst (
        .cpu_clk_50M (cpu_clk_50M),
        .arst_n_i    (arst_n_i),
        .is_div_i    (is_div),
        .div_req_i   (div_req),
        .div_done_i  (div_done),
        .stall_i     (stall_o)
    );

    initial begin
        cpu_clk_50M = 1'b0;
        forever #(CLK_PERIOD/2) cpu_clk_50M = ~cpu_clk_50M;
    end

    task automatic report_failure();
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_wb(input exe_wb_t act, input exe_wb_t exp);
        if (act !== exp) begin
            $display("mismatch wb_o (vector %0d): got 0x%h expected 0x%h", cur_vec, act, exp);
            report_failure();
        end
    endtask

    task automatic check_hilo(input hilo_wr_t act, input hilo_wr_t exp);
        logic bad;
        bad = (act.whi !== exp.whi) || (act.wlo !== exp.wlo);
        // a half is only meaningful with its write flag
        if (exp.whi && (act.hilo.hi !== exp.hilo.hi)) bad = 1'b1;
        if (exp.wlo && (act.hilo.lo !== exp.hilo.lo)) bad = 1'b1;
        if (bad) begin
            $display("mismatch hilo_wr_o (vector %0d): got 0x%h expected 0x%h",
                     cur_vec, act, exp);
            report_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("mismatch %s (vector %0d): got 0x%h expected 0x%h", name, cur_vec, act, exp);
            report_failure();
        end
    endtask

    task automatic load_vector(input int idx);
        int b;
        b = idx * NUM_FIELDS;
        req_i.alutype = alutype_e'(vec_mem[b][2:0]);
        req_i.aluop   = aluop_e'(vec_mem[b+1][7:0]);
        req_i.src1    = vec_mem[b+2];
        req_i.src2    = vec_mem[b+3];
        req_i.wa      = vec_mem[b+4][`EXE_REG_ADDR_W-1:0];
        req_i.wreg    = vec_mem[b+5][0];
        hilo_i        = {vec_mem[b+6], vec_mem[b+7]};
        mem_fwd_i     = {vec_mem[b+8][1:0], vec_mem[b+9], vec_mem[b+10]};
        wb_fwd_i      = {vec_mem[b+11][1:0], vec_mem[b+12], vec_mem[b+13]};
        // wa and wreg pass straight through
        exp_wb.wa     = req_i.wa;
        exp_wb.wreg   = req_i.wreg;
        exp_wb.wd     = vec_mem[b+14];
        exp_hilo      = {vec_mem[b+15][1:0], vec_mem[b+16], vec_mem[b+17]};
        exp_ov        = vec_mem[b+18][0];
    endtask

    // no HI/LO write may leave while the pipe is stalled
    task automatic wait_div_done();
        int cycles;
        cycles = 0;
        check_flag("stall_o", stall_o, 1'b1);
        while (stall_o && (cycles < DIV_TIMEOUT)) begin
            check_flag("hilo_wr_o.whi", hilo_wr_o.whi, 1'b0);
            check_flag("hilo_wr_o.wlo", hilo_wr_o.wlo, 1'b0);
            @(posedge cpu_clk_50M);
            #(SAMPLE_OFS);
            cycles++;
        end
        if (stall_o) begin
            $display("vector %0d: divide never finished, stall_o still high after %0d cycles",
                     cur_vec, cycles);
            report_failure();
        end
    endtask

    initial begin
        int n;
        cur_vec   = -1;
        arst_n_i  = 1'b0;
        req_i     = '0;
        hilo_i    = '0;
        mem_fwd_i = '0;
        wb_fwd_i  = '0;
        $readmemh("verif/exe_testdata.hex", vec_mem);

        repeat (2) @(posedge cpu_clk_50M);
        #(DRIVE_DLY);
        arst_n_i = 1'b1;
        #(SAMPLE_DLY);
        // idle after reset with a NOP in the stage
        check_flag("stall_o", stall_o, 1'b0);
        check_flag("hilo_wr_o.whi", hilo_wr_o.whi, 1'b0);
        check_flag("hilo_wr_o.wlo", hilo_wr_o.wlo, 1'b0);

        n = 0;
        while ((n < MAX_VEC) && (vec_mem[n*NUM_FIELDS] != END_MARK)) begin
            @(posedge cpu_clk_50M);
            #(DRIVE_DLY);
            cur_vec = n;
            load_vector(n);
            #(SAMPLE_DLY);
            if ((req_i.aluop == OP_DIV) || (req_i.aluop == OP_DIVU)) begin
                wait_div_done();
            end
            check_wb(wb_o, exp_wb);
            check_hilo(hilo_wr_o, exp_hilo);
            check_flag("ov_o", ov_o, exp_ov);
            n++;
        end

        if ((n == 0) || (n >= MAX_VEC)) begin
            $display("verif/exe_testdata.hex gave no vectors or lacks its end marker");
            report_failure();
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verif/exe_testdata.hex
// ty op src1 src2 wa wreg, hilo_i hi lo, mem_fwd fl hi lo, wb_fwd fl hi lo, exp wd fl hi lo ov
// fl: bit1 writes hi, bit0 writes lo; a line of just ff ends the list
1 01 f0f0ff00 0ff0f00f 03 1 0 0 0 0 0 0 0 0 00f0f000 0 0 0 0
1 02 f0f0ff00 0ff0f00f 04 1 0 0 0 0 0 0 0 0 fff0ff0f 0 0 0 0
1 03 f0f0ff00 0ff0f00f 05 1 0 0 0 0 0 0 0 0 ff000f0f 0 0 0 0
1 04 f0f0ff00 0ff0f00f 06 1 0 0 0 0 0 0 0 0 000f00f0 0 0 0 0
1 05 0 12340000 07 1 0 0 0 0 0 0 0 0 12340000 0 0 0 0
2 06 ffffffe4 000000ff 08 1 0 0 0 0 0 0 0 0 00000ff0 0 0 0 0
2 07 00000008 80000000 09 1 0 0 0 0 0 0 0 0 00800000 0 0 0 0
2 08 00000004 80000000 0a 1 0 0 0 0 0 0 0 0 f8000000 0 0 0 0
2 09 00000123 0000000f 0b 1 0 0 0 0 0 0 0 0 00000078 0 0 0 0
2 0a 0000001f 80000001 0c 1 0 0 0 0 0 0 0 0 00000001 0 0 0 0
2 0b 0000003c 87654321 0d 1 0 0 0 0 0 0 0 0 fffffff8 0 0 0 0
3 0c 00000005 fffffffd 0e 1 0 0 0 0 0 0 0 0 00000002 0 0 0 0
3 0c 7fffffff 00000001 0f 1 0 0 0 0 0 0 0 0 80000000 0 0 0 1
3 0c 80000000 80000000 18 1 0 0 0 0 0 0 0 0 00000000 0 0 0 1
3 0d 7fffffff 00000001 10 1 0 0 0 0 0 0 0 0 80000000 0 0 0 0
3 0e 00000003 00000005 11 1 0 0 0 0 0 0 0 0 fffffffe 0 0 0 0
3 0e 80000000 00000001 12 1 0 0 0 0 0 0 0 0 7fffffff 0 0 0 1
3 0f 80000000 00000001 13 1 0 0 0 0 0 0 0 0 7fffffff 0 0 0 0
3 10 ffffffff 00000001 14 1 0 0 0 0 0 0 0 0 00000001 0 0 0 0
3 10 80000000 7fffffff 17 1 0 0 0 0 0 0 0 0 00000001 0 0 0 0
3 11 ffffffff 00000001 15 1 0 0 0 0 0 0 0 0 00000000 0 0 0 0
3 11 00000001 ffffffff 16 0 0 0 0 0 0 0 0 0 00000001 0 0 0 0
0 12 fffffffe 00000003 0 0 0 0 0 0 0 0 0 0 0 3 ffffffff fffffffa 0
0 12 80000000 80000000 0 0 0 0 0 0 0 0 0 0 0 3 40000000 00000000 0
0 12 12345678 ffffffff 0 0 0 0 0 0 0 0 0 0 0 3 ffffffff edcba988 0
0 13 fffffffe 00000003 0 0 0 0 0 0 0 0 0 0 0 3 00000002 fffffffa 0
0 13 ffffffff ffffffff 0 0 0 0 0 0 0 0 0 0 0 3 fffffffe 00000001 0
0 14 0000000e fffffffb 0 0 0 0 0 0 0 0 0 0 0 3 00000004 fffffffe 0
0 14 fffffff1 00000004 0 0 0 0 0 0 0 0 0 0 0 3 fffffffd fffffffd 0
0 14 ffffffec fffffffa 0 0 0 0 0 0 0 0 0 0 0 3 fffffffe 00000003 0
0 14 80000000 00000003 0 0 0 0 0 0 0 0 0 0 0 3 fffffffe d5555556 0
0 15 ffffffff 00000010 0 0 0 0 0 0 0 0 0 0 0 3 0000000f 0fffffff 0
0 15 80000000 00000003 0 0 0 0 0 0 0 0 0 0 0 3 00000002 2aaaaaaa 0
0 14 12345678 00000000 0 0 0 0 0 0 0 0 0 0 0 3 00000000 00000000 0
0 15 ffffffff 00000000 0 0 0 0 0 0 0 0 0 0 0 3 00000000 00000000 0
4 16 0 0 05 1 11111111 22222222 0 0 0 0 0 0 11111111 0 0 0 0
4 16 0 0 05 1 11111111 22222222 0 0 0 2 33333333 0 33333333 0 0 0 0
4 16 0 0 05 1 11111111 22222222 2 44444444 0 2 33333333 0 44444444 0 0 0 0
4 16 0 0 05 1 11111111 22222222 1 0 66666666 2 33333333 0 33333333 0 0 0 0
4 17 0 0 06 1 11111111 22222222 2 44444444 0 1 0 55555555 55555555 0 0 0 0
4 17 0 0 06 1 11111111 22222222 1 0 66666666 3 33333333 55555555 66666666 0 0 0 0
4 17 0 0 06 1 11111111 22222222 0 0 0 0 0 0 22222222 0 0 0 0
0 18 a5a5a5a5 0 0 0 11111111 22222222 0 0 0 0 0 0 0 2 a5a5a5a5 0 0
0 19 5a5a5a5a 0 0 0 11111111 22222222 0 0 0 0 0 0 0 1 0 5a5a5a5a 0
0 00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
ff
